//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_wb_top -f sources.f \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_wb_top > sim.log 2>&1
grep -qx "TESTBENCH PASSED" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- sources.f
+incdir+include
verilog/wb_pkg.sv
verilog/wb_manager.sv
verilog/wb_arbiter.sv
verilog/wb_sram.sv
verilog/wb_dual_port_top.sv
verif/tb_wb_top.sv

//--- include/tb_wb_tasks.svh
// wishbone testbench helpers
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// 32 bit lcg
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// sram word index, address bits 9 down to 2
function automatic logic [7:0] word_index(input logic [WB_ADR_W-1:0] adr);
    return adr[9:2];
endfunction

function automatic logic [WB_DAT_W-1:0] fill_word(input logic [WB_ADR_W-1:0] adr);
    return adr ^ {adr[15:0], adr[31:16]} ^ 32'ha5c3_0f96;
endfunction

function automatic logic [WB_DAT_W-1:0] model_read(input logic [WB_ADR_W-1:0] adr);
    return model[word_index(adr)].word;
endfunction

// only the selected lanes change
function automatic void model_write(input logic [WB_ADR_W-1:0] adr,
        input logic [WB_DAT_W-1:0] data, input logic [WB_SEL_W-1:0] sel);
    wb_word_u src;
    wb_word_u dst;
    src.word = data;
    dst      = model[word_index(adr)];
    for (int i = 0; i < WB_SEL_W; i++) begin
        if (sel[i]) begin
            dst.lanes[i] = src.lanes[i];
        end
    end
    model[word_index(adr)] = dst;
endfunction

function automatic cpu_req_t make_req(input logic [WB_ADR_W-1:0] adr,
        input logic [WB_DAT_W-1:0] data, input logic [WB_SEL_W-1:0] sel,
        input logic write, input logic read);
    cpu_req_t req;
    req.adr   = adr;
    req.wdata = data;
    req.sel   = sel;
    req.write = write;
    req.read  = read;
    return req;
endfunction

task automatic check_word(input string what, input logic [WB_DAT_W-1:0] got,
        input logic [WB_DAT_W-1:0] want);
    if (got !== want) begin
        err_cnt++;
        $display("** Error: at %0d ns: %s, got %h expected %h", $time, what, got, want);
    end
endtask

task automatic check_bit(input string what, input logic got, input logic want);
    if (got !== want) begin
        err_cnt++;
        $display("** Error: at %0d ns: %s, got %b expected %b", $time, what, got, want);
    end
endtask

task automatic apply_reset();
    @(negedge CLK);
    nRST = 1'b0;
    repeat (2) @(negedge CLK);
    nRST   = 1'b1;
    held_a = '0;
    held_b = '0;
endtask

task automatic drive_req(input logic port_b, input cpu_req_t req);
    if (port_b) begin
        cpu_b_req = req;
    end else begin
        cpu_a_req = req;
    end
endtask

task automatic drop_req(input logic port_b);
    if (port_b) begin
        cpu_b_req.write = 1'b0;
        cpu_b_req.read  = 1'b0;
    end else begin
        cpu_a_req.write = 1'b0;
        cpu_a_req.read  = 1'b0;
    end
endtask

// the cycle counter bounds this wait
task automatic wait_idle();
    while (cpu_a_busy || cpu_b_busy) begin
        @(negedge CLK);
    end
endtask

// request held one cycle, then wait for busy to fall
task automatic run_txn(input logic port_b, input cpu_req_t req);
    @(negedge CLK);
    drive_req(port_b, req);
    @(negedge CLK);
    drop_req(port_b);
    check_bit("busy while in flight", port_b ? cpu_b_busy : cpu_a_busy, 1'b1);
    wait_idle();
    @(negedge CLK);
    check_bit("busy after completion", port_b ? cpu_b_busy : cpu_a_busy, 1'b0);
endtask

task automatic write_word(input logic port_b, input logic [WB_ADR_W-1:0] adr,
        input logic [WB_DAT_W-1:0] data, input logic [WB_SEL_W-1:0] sel);
    run_txn(port_b, make_req(adr, data, sel, 1'b1, 1'b0));
    model_write(adr, data, sel);
endtask

task automatic read_word(input logic port_b, input logic [WB_ADR_W-1:0] adr);
    logic [WB_DAT_W-1:0] want;
    want = model_read(adr);
    run_txn(port_b, make_req(adr, '0, '1, 1'b0, 1'b1));
    if (port_b) begin
        check_word("port b read data", cpu_b_rdata, want);
        held_b = want;
    end else begin
        check_word("port a read data", cpu_a_rdata, want);
        held_a = want;
    end
endtask

// read data only moves on a read of the same port
task automatic check_held();
    check_word("port a held data", cpu_a_rdata, held_a);
    check_word("port b held data", cpu_b_rdata, held_b);
endtask

task automatic start_test();
    test_err_start = err_cnt;
endtask

task automatic finish_test(input string name);
    if (err_cnt == test_err_start) begin
        tests_passed++;
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", name, err_cnt - test_err_start);
    end
endtask

`endif

//--- verif/tb_wb_top.sv
// dual port wishbone testbench
`timescale 1ns/10ps

module tb_wb_top
    import wb_pkg::*;
();

    // about 200 transactions at 12 cycles worst case, doubled
    localparam int MAX_TXNS       = 200;
    localparam int WORST_CYCLES   = 12;
    localparam int TIMEOUT_CYCLES = 2 * MAX_TXNS * WORST_CYCLES + 200;

    logic                CLK = 1'b0;
    logic                nRST;
    cpu_req_t            cpu_a_req;
    logic [WB_DAT_W-1:0] cpu_a_rdata;
    logic                cpu_a_busy;
    cpu_req_t            cpu_b_req;
    logic [WB_DAT_W-1:0] cpu_b_rdata;
    logic                cpu_b_busy;

    int                  cycle_cnt = 0;
    int                  err_cnt;
    int                  test_err_start;
    int                  tests_passed;
    int                  tests_failed;
    logic [31:0]         lcg_state;
    wb_word_u            model [SRAM_WORDS];
    logic [WB_DAT_W-1:0] held_a;
    logic [WB_DAT_W-1:0] held_b;

    wb_dual_port_top dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .cpu_a_req   (cpu_a_req),
        .cpu_a_rdata (cpu_a_rdata),
        .cpu_a_busy  (cpu_a_busy),
        .cpu_b_req   (cpu_b_req),
        .cpu_b_rdata (cpu_b_rdata),
        .cpu_b_busy  (cpu_b_busy)
    );

    `include "tb_wb_tasks.svh"

    always #2 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic test_reset_state();
        start_test();
        check_bit("port a busy after reset", cpu_a_busy, 1'b0);
        check_bit("port b busy after reset", cpu_b_busy, 1'b0);
        check_word("port a data after reset", cpu_a_rdata, '0);
        check_word("port b data after reset", cpu_b_rdata, '0);
        finish_test("reset state");
    endtask

    task automatic test_write_read();
        start_test();
        write_word(1'b0, 32'h0000_0010, lcg_next(), 4'hf);
        read_word(1'b0, 32'h0000_0010);
        finish_test("write then read");
    endtask

    task automatic test_byte_lanes();
        logic [15:0] sels;
        start_test();
        sels = 16'ha861;
        write_word(1'b1, 32'h0000_0080, 32'h1122_3344, 4'hf);
        for (int i = 0; i < 4; i++) begin
            write_word(1'b1, 32'h0000_0080, lcg_next(), sels[i*4 +: 4]);
            read_word(1'b1, 32'h0000_0080);
        end
        finish_test("byte lanes");
    endtask

    task automatic test_ignored_request();
        start_test();
        @(negedge CLK);
        drive_req(1'b0, make_req(32'h0000_0010, ~model_read(32'h0000_0010), 4'hf, 1'b1, 1'b1));
        @(negedge CLK);
        drop_req(1'b0);
        repeat (4) begin
            check_bit("busy on read plus write request", cpu_a_busy, 1'b0);
            @(negedge CLK);
        end
        read_word(1'b0, 32'h0000_0010);
        finish_test("ignored request");
    endtask

    // same cycle requests, port b still queued when port a finishes
    task automatic run_tie(input cpu_req_t req_a, input cpu_req_t req_b);
        @(negedge CLK);
        drive_req(1'b0, req_a);
        drive_req(1'b1, req_b);
        @(negedge CLK);
        drop_req(1'b0);
        drop_req(1'b1);
        while (cpu_a_busy) begin
            @(negedge CLK);
        end
        check_bit("port b waits behind port a", cpu_b_busy, 1'b1);
        wait_idle();
    endtask

    task automatic test_round_robin();
        logic [WB_DAT_W-1:0] val_x;
        logic [WB_DAT_W-1:0] val_y;
        start_test();
        val_x = lcg_next();
        val_y = lcg_next();
        // fresh reset, port b counts as last served
        apply_reset();
        run_tie(make_req(32'h40, val_x, 4'hf, 1'b1, 1'b0), make_req(32'h40, '0, 4'hf, 1'b0, 1'b1));
        model_write(32'h40, val_x, 4'hf);
        held_b = model_read(32'h40);
        check_word("port b reads port a write", cpu_b_rdata, held_b);
        run_tie(make_req(32'h40, '0, 4'hf, 1'b0, 1'b1), make_req(32'h40, val_y, 4'hf, 1'b1, 1'b0));
        held_a = model_read(32'h40);
        check_word("port a reads ahead of port b write", cpu_a_rdata, held_a);
        model_write(32'h40, val_y, 4'hf);
        read_word(1'b0, 32'h40);
        finish_test("round robin");
    endtask

    task automatic test_random_traffic();
        logic [31:0]         r;
        logic [WB_ADR_W-1:0] adr;
        start_test();
        // known contents in the 16 word window
        for (int i = 0; i < 16; i++) begin
            adr = 32'h0000_0100 + 32'(i * 4);
            write_word(i[0], adr, fill_word(adr), 4'hf);
        end
        repeat (64) begin
            r   = lcg_next();
            // upper bits random, so the index wraps into the window
            adr = {r[21:0], 4'b0100, r[29:26], 2'b00};
            if (r[30]) begin
                write_word(r[31], adr, lcg_next(), r[25:22]);
            end else begin
                read_word(r[31], adr);
            end
            check_held();
        end
        finish_test("random traffic");
    endtask

    initial begin
        nRST         = 1'b0;
        cpu_a_req    = '0;
        cpu_b_req    = '0;
        err_cnt      = 0;
        tests_passed = 0;
        tests_failed = 0;
        lcg_state    = 32'h559;
        apply_reset();
        test_reset_state();
        test_write_read();
        test_byte_lanes();
        test_ignored_request();
        test_round_robin();
        test_random_traffic();
        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/wb_arbiter.sv
// two way round robin bus arbiter
`timescale 1ns/10ps

module wb_arbiter
    import wb_pkg::*;
(
    input  logic    CLK,
    input  logic    nRST,

    // manager a
    input  wb_req_t m_a_req,
    output wb_rsp_t m_a_rsp,

    // manager b
    input  wb_req_t m_b_req,
    output wb_rsp_t m_b_rsp,

    // shared bus
    output wb_req_t bus_req,
    input  wb_rsp_t bus_rsp
);

    logic gnt_valid;
    logic gnt_b;
    logic last_b;
    logic pick_b;
    logic gnt_cyc;
    logic sel_a;
    logic sel_b;

    // b wins only if a is absent or a was served last
    assign pick_b  = m_b_req.cyc && (!m_a_req.cyc || !last_b);

    assign gnt_cyc = gnt_b ? m_b_req.cyc : m_a_req.cyc;
    assign sel_a   = gnt_valid && !gnt_b;
    assign sel_b   = gnt_valid && gnt_b;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            gnt_valid <= 1'b0;
            gnt_b     <= 1'b0;
            // a takes the first tie
            last_b    <= 1'b1;
        end else if (!gnt_valid) begin
            if (m_a_req.cyc || m_b_req.cyc) begin
                gnt_valid <= 1'b1;
                gnt_b     <= pick_b;
                last_b    <= pick_b;
            end
        end else if (!gnt_cyc) begin
            // owner has finished its cycle
            gnt_valid <= 1'b0;
        end
    end

    // shared bus mux, idle when nobody holds the grant
    always_comb begin
        bus_req = '0;
        if (sel_a) begin
            bus_req = m_a_req;
        end else if (sel_b) begin
            bus_req = m_b_req;
        end
    end

    // responses only reach the owner
    always_comb begin
        m_a_rsp     = '0;
        m_b_rsp     = '0;
        if (sel_a) begin
            m_a_rsp = bus_rsp;
        end
        if (sel_b) begin
            m_b_rsp = bus_rsp;
        end
    end

    acks_exclusive: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(m_a_rsp.ack && m_b_rsp.ack)
    );

    // no handover in the middle of a bus cycle
    grant_held_during_cycle: assert property (
        @(posedge CLK) disable iff (!nRST)
        (gnt_valid && gnt_cyc) |=> (gnt_valid && $stable(gnt_b))
    );

endmodule

//--- verilog/wb_dual_port_top.sv
// dual requester wishbone subsystem
`timescale 1ns/10ps

module wb_dual_port_top
    import wb_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,

    // processor port a
    input  cpu_req_t            cpu_a_req,
    output logic [WB_DAT_W-1:0] cpu_a_rdata,
    output logic                cpu_a_busy,

    // processor port b
    input  cpu_req_t            cpu_b_req,
    output logic [WB_DAT_W-1:0] cpu_b_rdata,
    output logic                cpu_b_busy
);

    wb_req_t mgr_a_bus;
    wb_rsp_t mgr_a_rsp;
    wb_req_t mgr_b_bus;
    wb_rsp_t mgr_b_rsp;
    wb_req_t shared_req;
    wb_rsp_t shared_rsp;

    wb_manager mgr_a (
        .CLK       (CLK),
        .nRST      (nRST),
        .cpu_req   (cpu_a_req),
        .cpu_rdata (cpu_a_rdata),
        .busy      (cpu_a_busy),
        .wb_out    (mgr_a_bus),
        .wb_in     (mgr_a_rsp)
    );

    wb_manager mgr_b (
        .CLK       (CLK),
        .nRST      (nRST),
        .cpu_req   (cpu_b_req),
        .cpu_rdata (cpu_b_rdata),
        .busy      (cpu_b_busy),
        .wb_out    (mgr_b_bus),
        .wb_in     (mgr_b_rsp)
    );

    wb_arbiter arbiter (
        .CLK     (CLK),
        .nRST    (nRST),
        .m_a_req (mgr_a_bus),
        .m_a_rsp (mgr_a_rsp),
        .m_b_req (mgr_b_bus),
        .m_b_rsp (mgr_b_rsp),
        .bus_req (shared_req),
        .bus_rsp (shared_rsp)
    );

    wb_sram sram (
        .CLK     (CLK),
        .nRST    (nRST),
        .bus_req (shared_req),
        .bus_rsp (shared_rsp)
    );

endmodule

//--- verilog/wb_manager.sv
// wishbone bus manager
`timescale 1ns/10ps

module wb_manager
    import wb_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,

    // processor side
    input  cpu_req_t            cpu_req,
    output logic [WB_DAT_W-1:0] cpu_rdata,
    output logic                busy,

    // bus side
    output wb_req_t             wb_out,
    input  wb_rsp_t             wb_in
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ
    } state_t;

    state_t              state;
    state_t              next_state;
    wb_req_t             next_out;
    logic                next_busy;
    logic [WB_DAT_W-1:0] next_rdata;
    logic                valid_req;

    // exactly one of read and write, otherwise ignored
    assign valid_req = cpu_req.write ^ cpu_req.read;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            wb_out    <= '0;
            busy      <= 1'b0;
            cpu_rdata <= '0;
        end else begin
            state     <= next_state;
            wb_out    <= next_out;
            busy      <= next_busy;
            cpu_rdata <= next_rdata;
        end
    end

    // bus cycle sequencing
    always_comb begin
        next_state = state;
        next_out   = wb_out;
        next_busy  = busy;

        case (state)
            IDLE: begin
                if (valid_req) begin
                    next_out.adr = cpu_req.adr;
                    next_out.sel = cpu_req.sel;
                    next_out.we  = cpu_req.write;
                    next_out.stb = 1'b1;
                    next_out.cyc = 1'b1;
                    next_busy    = 1'b1;
                    if (cpu_req.write) begin
                        next_out.dat = cpu_req.wdata;
                        next_state   = WRITE;
                    end else begin
                        next_out.dat = '0;
                        next_state   = READ;
                    end
                end
            end

            // hold the cycle until the subordinate acks
            WRITE, READ: begin
                if (wb_in.ack) begin
                    next_out   = '0;
                    next_busy  = 1'b0;
                    next_state = IDLE;
                end
            end

            default: begin
                next_out   = '0;
                next_busy  = 1'b0;
                next_state = IDLE;
            end
        endcase
    end

    // read data stays put until the next read completes
    always_comb begin
        next_rdata = cpu_rdata;
        if ((state == READ) && wb_in.ack) begin
            next_rdata = wb_in.dat;
        end
    end

    stb_implies_cyc: assert property (
        @(posedge CLK) disable iff (!nRST)
        wb_out.stb |-> wb_out.cyc
    );

    // busy covers exactly the bus cycle
    busy_matches_cyc: assert property (
        @(posedge CLK) disable iff (!nRST)
        busy == wb_out.cyc
    );

endmodule

//--- verilog/wb_pkg.sv
// wishbone subsystem types
package wb_pkg;

    // bus geometry
    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = 4;

    // sram sizing and response latency
    localparam int SRAM_WORDS = 256;
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);
    localparam int SRAM_WAIT  = 1;
    localparam int WAIT_CNT_W = $clog2(SRAM_WAIT + 1);

    // processor side request, held as a level
    typedef struct packed {
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] wdata;
        logic [WB_SEL_W-1:0] sel;
        logic                write;
        logic                read;
    } cpu_req_t;

    // manager to bus
    typedef struct packed {
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
        logic [WB_SEL_W-1:0] sel;
        logic                we;
        logic                stb;
        logic                cyc;
    } wb_req_t;

    // bus to manager
    typedef struct packed {
        logic [WB_DAT_W-1:0] dat;
        logic                ack;
    } wb_rsp_t;

    // one data word, seen whole or as byte lanes
    typedef union packed {
        logic [WB_DAT_W-1:0]          word;
        logic [WB_SEL_W-1:0][7:0]     lanes;
    } wb_word_u;

endpackage

//--- verilog/wb_sram.sv
// wishbone sram with byte lanes
`timescale 1ns/10ps

module wb_sram
    import wb_pkg::*;
(
    input  logic    CLK,
    input  logic    nRST,
    input  wb_req_t bus_req,
    output wb_rsp_t bus_rsp
);

    wb_word_u mem [SRAM_WORDS];

    logic [SRAM_IDX_W-1:0] idx;
    logic [WAIT_CNT_W-1:0] wait_cnt;
    logic                  ack_q;
    logic                  access;
    wb_word_u              wr_word;
    wb_word_u              merged;

    // word address, wraps over the depth
    assign idx    = bus_req.adr[SRAM_IDX_W+1:2];
    assign access = bus_req.stb && bus_req.cyc;

    // wait states before the single cycle ack
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
            ack_q    <= 1'b0;
        end else if (access && !ack_q) begin
            if (wait_cnt == WAIT_CNT_W'(SRAM_WAIT - 1)) begin
                ack_q    <= 1'b1;
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end else begin
            ack_q    <= 1'b0;
            wait_cnt <= '0;
        end
    end

    // merge selected lanes into the stored word
    always_comb begin
        wr_word.word = bus_req.dat;
        merged       = mem[idx];
        for (int i = 0; i < WB_SEL_W; i++) begin
            if (bus_req.sel[i]) begin
                merged.lanes[i] = wr_word.lanes[i];
            end
        end
    end

    // write lands on the ack edge
    always_ff @(posedge CLK) begin
        if (ack_q && access && bus_req.we) begin
            mem[idx] <= merged;
        end
    end

    assign bus_rsp.dat = mem[idx].word;
    assign bus_rsp.ack = ack_q;

    // the manager must keep STB up until it sees the ack
    ack_within_stb: assert property (
        @(posedge CLK) disable iff (!nRST)
        bus_rsp.ack |-> bus_req.stb
    );

endmodule
